/* source/mem_pkg.sv */
// Memory emulator package with access kinds, widths, exception codes and answer layout
package mem_pkg;

    // ------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int TAG_W  = 4;
    localparam int ANS_W  = 128;

    // Access kind of a request
    typedef enum logic [1:0] {
        MEM_ACC_INSTR = 2'h0,
        MEM_ACC_LD    = 2'h1,
        MEM_ACC_ST    = 2'h2
    } mem_acc_t;

    // Load/store width, unsigned variants zero-extend on load
    typedef enum logic [2:0] {
        LS_BYTE       = 3'h0,
        LS_BYTE_U     = 3'h1,
        LS_HALFWORD   = 3'h2,
        LS_HALFWORD_U = 3'h3,
        LS_WORD       = 3'h4,
        LS_WORD_U     = 3'h5,
        LS_DOUBLEWORD = 3'h6
    } ls_type_t;

    // Exception causes, numbered after the RISC-V mcause values
    typedef enum logic [3:0] {
        E_I_ADDR_MISALIGNED  = 4'h0,
        E_I_ACCESS_FAULT     = 4'h1,
        E_LD_ADDR_MISALIGNED = 4'h4,
        E_LD_ACCESS_FAULT    = 4'h5,
        E_ST_ADDR_MISALIGNED = 4'h6,
        E_ST_ACCESS_FAULT    = 4'h7,
        E_UNKNOWN            = 4'hf
    } except_code_t;

    // ------------------------------------------------------------
    // Answer layout
    // ------------------------------------------------------------
    localparam int ANS_PAD_W = ANS_W - (TAG_W + $bits(mem_acc_t) + ADDR_W + DATA_W + 1
                                        + $bits(except_code_t));

    typedef struct packed {
        logic [ANS_PAD_W-1:0] pad;
        logic [TAG_W-1:0]     tag;
        mem_acc_t             acc_type;
        logic [ADDR_W-1:0]    addr;
        logic [DATA_W-1:0]    value;
        logic                 except_raised;
        except_code_t         except_code;
    } mem_ans_t;

    // Size in bytes of an access, fetches are always one word
    function automatic logic [3:0] access_bytes(mem_acc_t acc, ls_type_t ls);
        logic [3:0] nbytes;
        if (acc == MEM_ACC_INSTR) begin
            nbytes = 4'd4;
        end else begin
            case (ls)
                LS_BYTE, LS_BYTE_U:         nbytes = 4'd1;
                LS_HALFWORD, LS_HALFWORD_U: nbytes = 4'd2;
                LS_WORD, LS_WORD_U:         nbytes = 4'd4;
                default:                    nbytes = 4'd8;
            endcase
        end
        return nbytes;
    endfunction

endpackage

/* source/spill_cell.sv */
// Spill cell, a two-entry valid/ready register stage generic in its payload
`timescale 1ns/1ps

module spill_cell #(
    parameter type DATA_T = logic [31:0]
) (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  valid_i,
    output logic  ready_o,
    input  DATA_T data_i,
    output logic  valid_o,
    input  logic  ready_i,
    output DATA_T data_o
);

    logic  main_valid_q;
    logic  spill_valid_q;
    DATA_T main_data_q;
    DATA_T spill_data_q;
    logic  main_free;
    logic  in_fire;

    // Main entry can load when empty or when its content leaves now
    assign main_free = ~main_valid_q | ready_i;
    assign in_fire   = valid_i & ready_o;

    // ------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            main_valid_q  <= 1'b0;
            spill_valid_q <= 1'b0;
        end else if (main_free) begin
            if (spill_valid_q) begin
                // Spill entry moves up, no input accepted this cycle
                main_valid_q  <= 1'b1;
                spill_valid_q <= 1'b0;
            end else begin
                main_valid_q <= in_fire;
            end
        end else if (in_fire) begin
            spill_valid_q <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (main_free) begin
            if (spill_valid_q) begin
                main_data_q <= spill_data_q;
            end else if (in_fire) begin
                main_data_q <= data_i;
            end
        end else if (in_fire) begin
            spill_data_q <= data_i;
        end
    end

    // Ready depends on the spill entry only, never on ready_i
    assign ready_o = ~spill_valid_q;
    assign valid_o = main_valid_q;
    assign data_o  = main_data_q;

endmodule

/* source/mem_cfg_regs.sv */
// Write-protect window configuration registers with read-back
`timescale 1ns/1ps

module mem_cfg_regs
    import mem_pkg::*;
(
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              cfg_we_i,
    input  logic [1:0]        cfg_addr_i,
    input  logic [ADDR_W-1:0] cfg_wdata_i,
    output logic [ADDR_W-1:0] cfg_rdata_o,
    output logic [ADDR_W-1:0] wp_base_o,
    output logic [ADDR_W-1:0] wp_limit_o,
    output logic              wp_en_o
);

    // Register map
    localparam logic [1:0] CFG_BASE  = 2'd0;
    localparam logic [1:0] CFG_LIMIT = 2'd1;
    localparam logic [1:0] CFG_EN    = 2'd2;

    // ------------------------------------------------------------
    // Window registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wp_base_o  <= '0;
            wp_limit_o <= '0;
            wp_en_o    <= 1'b0;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                CFG_BASE:  wp_base_o  <= cfg_wdata_i;
                CFG_LIMIT: wp_limit_o <= cfg_wdata_i;
                CFG_EN:    wp_en_o    <= cfg_wdata_i[0];
                default:   ;
            endcase
        end
    end

    // Read-back mux, unmapped address reads zero
    always_comb begin
        case (cfg_addr_i)
            CFG_BASE:  cfg_rdata_o = wp_base_o;
            CFG_LIMIT: cfg_rdata_o = wp_limit_o;
            CFG_EN:    cfg_rdata_o = {{(ADDR_W-1){1'b0}}, wp_en_o};
            default:   cfg_rdata_o = '0;
        endcase
    end

endmodule

/* source/mem_access_check.sv */
// Access checker for alignment, address range and store write protection
`timescale 1ns/1ps

module mem_access_check
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  mem_acc_t          acc_i,
    input  ls_type_t          ls_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [ADDR_W-1:0] wp_base_i,
    input  logic [ADDR_W-1:0] wp_limit_i,
    input  logic              wp_en_i,
    output logic              except_o,
    output except_code_t      code_o
);

    // One extra bit so the last-byte sum cannot wrap
    localparam logic [ADDR_W:0] MEM_BYTES = (ADDR_W+1)'(MEM_WORDS * 8);

    logic [3:0]      nbytes;
    logic [2:0]      align_mask;
    logic [ADDR_W:0] last_byte;
    logic            unknown_acc;
    logic            misaligned;
    logic            out_of_range;
    logic            wp_hit;
    logic            access_fault;

    assign nbytes     = access_bytes(acc_i, ls_i);
    assign align_mask = 3'(nbytes - 4'd1);
    assign last_byte  = {1'b0, addr_i} + (ADDR_W+1)'(nbytes) - (ADDR_W+1)'(1);

    // ------------------------------------------------------------
    // Individual checks
    // ------------------------------------------------------------
    assign unknown_acc  = !(acc_i inside {MEM_ACC_INSTR, MEM_ACC_LD, MEM_ACC_ST});
    assign misaligned   = (addr_i[2:0] & align_mask) != 3'b000;
    assign out_of_range = last_byte >= MEM_BYTES;

    // Window is inclusive at both ends and guards stores only
    assign wp_hit = wp_en_i && (acc_i == MEM_ACC_ST)
                    && (addr_i >= wp_base_i) && (addr_i <= wp_limit_i);

    assign access_fault = out_of_range | wp_hit;

    // ------------------------------------------------------------
    // Exception code, misalignment wins over a fault
    // ------------------------------------------------------------
    always_comb begin
        except_o = unknown_acc | misaligned | access_fault;
        code_o   = E_UNKNOWN;
        if (!unknown_acc) begin
            if (misaligned) begin
                case (acc_i)
                    MEM_ACC_INSTR: code_o = E_I_ADDR_MISALIGNED;
                    MEM_ACC_LD:    code_o = E_LD_ADDR_MISALIGNED;
                    default:       code_o = E_ST_ADDR_MISALIGNED;
                endcase
            end else if (access_fault) begin
                case (acc_i)
                    MEM_ACC_INSTR: code_o = E_I_ACCESS_FAULT;
                    MEM_ACC_LD:    code_o = E_LD_ACCESS_FAULT;
                    default:       code_o = E_ST_ACCESS_FAULT;
                endcase
            end
        end
    end

endmodule

/* source/mem_array.sv */
// Doubleword memory array with byte-lane writes and extended combinational reads
`timescale 1ns/1ps

module mem_array
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk_i,
    input  logic              we_i,
    input  ls_type_t          ls_i,
    input  mem_acc_t          acc_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int LANES = DATA_W / 8;

    logic [DATA_W-1:0] mem_q [MEM_WORDS];

    logic [IDX_W-1:0]  idx;
    logic [2:0]        offset;
    logic [3:0]        nbytes;
    logic [LANES-1:0]  lane_mask;
    logic [LANES-1:0]  byte_en;
    logic [DATA_W-1:0] wdata_shift;
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] shifted;

    assign idx    = addr_i[IDX_W+2:3];
    assign offset = addr_i[2:0];
    assign nbytes = access_bytes(acc_i, ls_i);

    // ------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------
    // Low bytes of wdata_i land on the lanes starting at offset
    assign lane_mask   = LANES'((9'h1 << nbytes) - 9'h1);
    assign byte_en     = lane_mask << offset;
    assign wdata_shift = wdata_i << {offset, 3'b000};

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < LANES; i++) begin
                if (byte_en[i]) begin
                    mem_q[idx][8*i +: 8] <= wdata_shift[8*i +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------
    assign word    = mem_q[idx];
    assign shifted = word >> {offset, 3'b000};

    always_comb begin
        if (acc_i == MEM_ACC_INSTR) begin
            // Fetch returns a zero-extended word
            rdata_o = {32'b0, shifted[31:0]};
        end else begin
            case (ls_i)
                LS_BYTE: begin
                    rdata_o = {{56{shifted[7]}}, shifted[7:0]};
                end
                LS_BYTE_U: begin
                    rdata_o = {56'b0, shifted[7:0]};
                end
                LS_HALFWORD: begin
                    rdata_o = {{48{shifted[15]}}, shifted[15:0]};
                end
                LS_HALFWORD_U: begin
                    rdata_o = {48'b0, shifted[15:0]};
                end
                LS_WORD: begin
                    rdata_o = {{32{shifted[31]}}, shifted[31:0]};
                end
                LS_WORD_U: begin
                    rdata_o = {32'b0, shifted[31:0]};
                end
                default: begin
                    rdata_o = shifted;
                end
            endcase
        end
    end

endmodule

/* source/mem_emu_top.sv */
// Memory emulator top level with config, checker, array and output register
`timescale 1ns/1ps

module mem_emu_top
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Request
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  logic [TAG_W-1:0]  req_tag_i,
    input  mem_acc_t          req_acc_i,
    input  ls_type_t          req_ls_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_value_i,
    // Answer
    output logic              ans_valid_o,
    input  logic              ans_ready_i,
    output logic [TAG_W-1:0]  ans_tag_o,
    output mem_acc_t          ans_acc_o,
    output logic [ADDR_W-1:0] ans_addr_o,
    output logic [DATA_W-1:0] ans_value_o,
    output logic              ans_except_o,
    output except_code_t      ans_code_o,
    // Configuration
    input  logic              cfg_we_i,
    input  logic [1:0]        cfg_addr_i,
    input  logic [ADDR_W-1:0] cfg_wdata_i,
    output logic [ADDR_W-1:0] cfg_rdata_o
);

    logic [ADDR_W-1:0] wp_base;
    logic [ADDR_W-1:0] wp_limit;
    logic              wp_en;
    logic              except;
    except_code_t      code;
    logic [DATA_W-1:0] rdata;
    logic              req_fire;
    logic              array_we;
    mem_ans_t          ans_in;
    mem_ans_t          ans_out;

    // ------------------------------------------------------------
    // Config, checker and storage
    // ------------------------------------------------------------
    mem_cfg_regs u_cfg_regs (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .wp_base_o   (wp_base),
        .wp_limit_o  (wp_limit),
        .wp_en_o     (wp_en)
    );

    mem_access_check #(
        .MEM_WORDS (MEM_WORDS)
    ) u_access_check (
        .acc_i      (req_acc_i),
        .ls_i       (req_ls_i),
        .addr_i     (req_addr_i),
        .wp_base_i  (wp_base),
        .wp_limit_i (wp_limit),
        .wp_en_i    (wp_en),
        .except_o   (except),
        .code_o     (code)
    );

    // Faulting stores never touch the array
    assign req_fire = req_valid_i & req_ready_o;
    assign array_we = req_fire & (req_acc_i == MEM_ACC_ST) & ~except;

    mem_array #(
        .MEM_WORDS (MEM_WORDS)
    ) u_array (
        .clk_i   (clk_i),
        .we_i    (array_we),
        .ls_i    (req_ls_i),
        .acc_i   (req_acc_i),
        .addr_i  (req_addr_i),
        .wdata_i (req_value_i),
        .rdata_o (rdata)
    );

    // ------------------------------------------------------------
    // Answer packing and output register
    // ------------------------------------------------------------
    always_comb begin
        ans_in.pad           = '0;
        ans_in.tag           = req_tag_i;
        ans_in.acc_type      = req_acc_i;
        ans_in.addr          = req_addr_i;
        ans_in.value         = (except || req_acc_i == MEM_ACC_ST) ? '0 : rdata;
        ans_in.except_raised = except;
        ans_in.except_code   = code;
    end

    spill_cell #(
        .DATA_T (mem_ans_t)
    ) u_spill_cell (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (req_valid_i),
        .ready_o  (req_ready_o),
        .data_i   (ans_in),
        .valid_o  (ans_valid_o),
        .ready_i  (ans_ready_i),
        .data_o   (ans_out)
    );

    assign ans_tag_o    = ans_out.tag;
    assign ans_acc_o    = ans_out.acc_type;
    assign ans_addr_o   = ans_out.addr;
    assign ans_value_o  = ans_out.value;
    assign ans_except_o = ans_out.except_raised;
    assign ans_code_o   = ans_out.except_code;

endmodule

/* test/mem_emu_sva.sv */
// Handshake assertions for the answer output register
`timescale 1ns/1ps

module mem_emu_sva #(
    parameter int PAYLOAD_W = 1
) (
    input logic                 clk_i,
    input logic                 arst_n_i,
    input logic                 in_ready_i,
    input logic                 out_valid_i,
    input logic                 out_ready_i,
    input logic [PAYLOAD_W-1:0] out_data_i
);

    // No answer may be offered while reset is active
    a_idle_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_i)
        else $error("Output register offers an answer during reset");

    // A stalled answer holds until it is taken
    a_stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
        else $error("Answer dropped or changed while stalled");

    a_ready_after_reset: assert property (@(posedge clk_i) $rose(arst_n_i) |-> in_ready_i)
        else $error("Output register not ready right after reset release");

endmodule

bind spill_cell mem_emu_sva #(
    .PAYLOAD_W ($bits(data_o))
) u_sva (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_ready_i  (ready_o),
    .out_valid_i (valid_o),
    .out_ready_i (ready_i),
    .out_data_i  (data_o)
);

/* test/tb_mem_emu.sv */
// Table-driven testbench for the memory emulator with random answer back-pressure
`timescale 1ns/1ps

module tb_mem_emu
    import mem_pkg::*;
();

    // Table step holding a config write or a request and its expected answer
    typedef struct packed {
        logic              is_cfg;
        logic [1:0]        cfg_addr;
        mem_acc_t          acc;
        ls_type_t          ls;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wval;
        logic [DATA_W-1:0] exp_val;
        logic              exp_exc;
        except_code_t      exp_code;
    } row_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        mem_acc_t          acc;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] value;
        logic              exc;
        except_code_t      code;
    } exp_t;

    logic              clk_i = 1'b0;
    logic              arst_n_i;
    logic              req_valid_i;
    logic              req_ready_o;
    logic [TAG_W-1:0]  req_tag_i;
    mem_acc_t          req_acc_i;
    ls_type_t          req_ls_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [DATA_W-1:0] req_value_i;
    logic              ans_valid_o;
    logic              ans_ready_i = 1'b0;
    logic [TAG_W-1:0]  ans_tag_o;
    mem_acc_t          ans_acc_o;
    logic [ADDR_W-1:0] ans_addr_o;
    logic [DATA_W-1:0] ans_value_o;
    logic              ans_except_o;
    except_code_t      ans_code_o;
    logic              cfg_we_i;
    logic [1:0]        cfg_addr_i;
    logic [ADDR_W-1:0] cfg_wdata_i;
    logic [ADDR_W-1:0] cfg_rdata_o;

    row_t              rows[$];
    exp_t              exp_q[$];
    logic [TAG_W-1:0]  next_tag;
    int                n_reqs = 0;
    int                n_answers = 0;
    int                cycles = 0;
    int                seed = 32'h359d_3076;

    always #5 clk_i = ~clk_i;

    mem_emu_top #(
        .MEM_WORDS (256)
    ) u_dut (
        .clk_i (clk_i), .arst_n_i (arst_n_i),
        .req_valid_i (req_valid_i), .req_ready_o (req_ready_o), .req_tag_i (req_tag_i),
        .req_acc_i (req_acc_i), .req_ls_i (req_ls_i), .req_addr_i (req_addr_i),
        .req_value_i (req_value_i),
        .ans_valid_o (ans_valid_o), .ans_ready_i (ans_ready_i), .ans_tag_o (ans_tag_o),
        .ans_acc_o (ans_acc_o), .ans_addr_o (ans_addr_o), .ans_value_o (ans_value_o),
        .ans_except_o (ans_except_o), .ans_code_o (ans_code_o),
        .cfg_we_i (cfg_we_i), .cfg_addr_i (cfg_addr_i), .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o)
    );

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    // ------------------------------------------------------------
    // Table building
    // ------------------------------------------------------------
    task automatic cfg_row(input logic [1:0] a, input logic [ADDR_W-1:0] wdata,
                           input logic [ADDR_W-1:0] readback);
        row_t r;
        r          = '0;
        r.is_cfg   = 1'b1;
        r.cfg_addr = a;
        r.wval     = DATA_W'(wdata);
        r.exp_val  = DATA_W'(readback);
        rows.push_back(r);
    endtask

    task automatic good_row(input mem_acc_t acc, input ls_type_t ls,
                            input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wval, input logic [DATA_W-1:0] exp_val);
        row_t r;
        r = '{1'b0, 2'd0, acc, ls, addr, wval, exp_val, 1'b0, E_UNKNOWN};
        rows.push_back(r);
        n_reqs++;
    endtask

    // Faulting requests always answer with value zero
    task automatic fault_row(input mem_acc_t acc, input ls_type_t ls,
                             input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wval, input except_code_t code);
        row_t r;
        r = '{1'b0, 2'd0, acc, ls, addr, wval, 64'h0, 1'b1, code};
        rows.push_back(r);
        n_reqs++;
    endtask

    task automatic build_table();
        // Full doublewords first and then single lanes overwritten
        good_row(MEM_ACC_ST, LS_DOUBLEWORD, 32'h100, 64'h8877_6655_4433_2211, 64'h0);
        good_row(MEM_ACC_ST, LS_DOUBLEWORD, 32'h108, 64'h0123_4567_89ab_cdef, 64'h0);
        good_row(MEM_ACC_ST, LS_BYTE, 32'h101, 64'hff, 64'h0);
        good_row(MEM_ACC_ST, LS_HALFWORD, 32'h104, 64'ha5c3, 64'h0);
        good_row(MEM_ACC_ST, LS_WORD, 32'h10c, 64'hdead_beef, 64'h0);
        good_row(MEM_ACC_LD, LS_DOUBLEWORD, 32'h100, 64'h0, 64'h8877_a5c3_4433_ff11);
        good_row(MEM_ACC_LD, LS_BYTE, 32'h101, 64'h0, 64'hffff_ffff_ffff_ffff);
        good_row(MEM_ACC_LD, LS_BYTE_U, 32'h101, 64'h0, 64'h0000_0000_0000_00ff);
        good_row(MEM_ACC_LD, LS_HALFWORD, 32'h104, 64'h0, 64'hffff_ffff_ffff_a5c3);
        good_row(MEM_ACC_LD, LS_HALFWORD_U, 32'h104, 64'h0, 64'h0000_0000_0000_a5c3);
        good_row(MEM_ACC_LD, LS_WORD, 32'h10c, 64'h0, 64'hffff_ffff_dead_beef);
        good_row(MEM_ACC_LD, LS_WORD_U, 32'h10c, 64'h0, 64'h0000_0000_dead_beef);
        good_row(MEM_ACC_LD, LS_WORD, 32'h100, 64'h0, 64'h0000_0000_4433_ff11);
        good_row(MEM_ACC_LD, LS_BYTE, 32'h107, 64'h0, 64'hffff_ffff_ffff_ff88);
        good_row(MEM_ACC_INSTR, LS_WORD, 32'h10c, 64'h0, 64'h0000_0000_dead_beef);
        // Misaligned accesses
        fault_row(MEM_ACC_INSTR, LS_WORD, 32'h102, 64'h0, E_I_ADDR_MISALIGNED);
        fault_row(MEM_ACC_LD, LS_HALFWORD, 32'h101, 64'h0, E_LD_ADDR_MISALIGNED);
        fault_row(MEM_ACC_LD, LS_DOUBLEWORD, 32'h104, 64'h0, E_LD_ADDR_MISALIGNED);
        fault_row(MEM_ACC_ST, LS_DOUBLEWORD, 32'h104, 64'h1111_2222_3333_4444,
                  E_ST_ADDR_MISALIGNED);
        fault_row(MEM_ACC_ST, LS_WORD, 32'h10a, 64'h5555_6666, E_ST_ADDR_MISALIGNED);
        fault_row(MEM_ACC_LD, LS_WORD, 32'h7fe, 64'h0, E_LD_ADDR_MISALIGNED);
        good_row(MEM_ACC_LD, LS_DOUBLEWORD, 32'h108, 64'h0, 64'hdead_beef_89ab_cdef);
        // Range limit at 2048 bytes where 0x900 would alias onto 0x100
        good_row(MEM_ACC_ST, LS_DOUBLEWORD, 32'h7f8, 64'hcafe_f00d_1234_5678, 64'h0);
        good_row(MEM_ACC_LD, LS_DOUBLEWORD, 32'h7f8, 64'h0, 64'hcafe_f00d_1234_5678);
        fault_row(MEM_ACC_LD, LS_DOUBLEWORD, 32'h800, 64'h0, E_LD_ACCESS_FAULT);
        fault_row(MEM_ACC_ST, LS_BYTE, 32'h800, 64'h42, E_ST_ACCESS_FAULT);
        fault_row(MEM_ACC_INSTR, LS_WORD, 32'h800, 64'h0, E_I_ACCESS_FAULT);
        fault_row(MEM_ACC_ST, LS_DOUBLEWORD, 32'h900, 64'h9999_9999_9999_9999, E_ST_ACCESS_FAULT);
        good_row(MEM_ACC_LD, LS_DOUBLEWORD, 32'h100, 64'h0, 64'h8877_a5c3_4433_ff11);
        // Write-protect window 0x200 to 0x2ff
        cfg_row(2'd0, 32'h200, 32'h200);
        cfg_row(2'd1, 32'h2ff, 32'h2ff);
        // Stores inside a disabled window still succeed
        good_row(MEM_ACC_ST, LS_DOUBLEWORD, 32'h200, 64'h0f0e_0d0c_0b0a_0908, 64'h0);
        cfg_row(2'd2, 32'h3, 32'h1);
        fault_row(MEM_ACC_ST, LS_DOUBLEWORD, 32'h200, 64'hffff_ffff_ffff_ffff, E_ST_ACCESS_FAULT);
        fault_row(MEM_ACC_ST, LS_BYTE, 32'h2ff, 64'h77, E_ST_ACCESS_FAULT);
        good_row(MEM_ACC_LD, LS_DOUBLEWORD, 32'h200, 64'h0, 64'h0f0e_0d0c_0b0a_0908);
        good_row(MEM_ACC_ST, LS_DOUBLEWORD, 32'h300, 64'h5555_aaaa_5555_aaaa, 64'h0);
        good_row(MEM_ACC_ST, LS_DOUBLEWORD, 32'h1f8, 64'h1234, 64'h0);
        good_row(MEM_ACC_LD, LS_DOUBLEWORD, 32'h1f8, 64'h0, 64'h0000_0000_0000_1234);
    endtask

    // ------------------------------------------------------------
    // Drivers called on the falling edge
    // ------------------------------------------------------------
    task automatic drive_cfg(input row_t r);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = r.cfg_addr;
        cfg_wdata_i = r.wval[ADDR_W-1:0];
        @(negedge clk_i);
        cfg_we_i = 1'b0;
        assert (cfg_rdata_o == r.exp_val[ADDR_W-1:0]) else begin
            $display("** Error at %0t: config register %0d reads %h, expected %h",
                     $time, r.cfg_addr, cfg_rdata_o, r.exp_val[ADDR_W-1:0]);
            abort_run();
        end
    endtask

    task automatic send_request(input row_t r);
        exp_t e;
        logic accepted;
        e = '{next_tag, r.acc, r.addr, r.exp_val, r.exp_exc, r.exp_code};
        exp_q.push_back(e);
        req_valid_i = 1'b1;
        req_tag_i   = next_tag;
        req_acc_i   = r.acc;
        req_ls_i    = r.ls;
        req_addr_i  = r.addr;
        req_value_i = r.wval;
        accepted    = 1'b0;
        // Ready only moves on a rising edge, so its value now holds at the next one
        while (!accepted) begin
            accepted = req_ready_o;
            @(negedge clk_i);
        end
        req_valid_i = 1'b0;
        next_tag    = next_tag + 4'd1;
    endtask

    // Random back-pressure and in-order answer checks
    always @(negedge clk_i) begin : check_answers
        exp_t e;
        int   rnd;
        if (arst_n_i) begin
            rnd         = $random(seed);
            ans_ready_i = (rnd & 3) != 0;
            if (ans_valid_o && ans_ready_i) begin
                assert (exp_q.size() > 0) else begin
                    $display("Answer with tag %0d arrived with no request outstanding",
                             ans_tag_o);
                    abort_run();
                end
                e = exp_q.pop_front();
                n_answers++;
                assert (ans_tag_o == e.tag && ans_acc_o == e.acc
                        && ans_addr_o == e.addr) else begin
                    $display("** Error at %0t: answer tag %0d kind %0d addr %h, expected %0d %0d %h",
                             $time, ans_tag_o, ans_acc_o, ans_addr_o, e.tag, e.acc, e.addr);
                    abort_run();
                end
                assert (ans_value_o == e.value && ans_except_o == e.exc
                        && (!e.exc || ans_code_o == e.code)) else begin
                    $display("** Error at %0t: tag %0d value %h exc %b code %0d, %s %h %b %0d",
                             $time, e.tag, ans_value_o, ans_except_o, ans_code_o,
                             "expected", e.value, e.exc, e.code);
                    abort_run();
                end
            end
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycles <= cycles + 1;
        if (cycles > 20 * rows.size() + 100) begin
            $display("Timeout after %0d cycles with %0d answers missing", cycles, exp_q.size());
            $display("Done: errors found");
            $fatal(1, "Cycle limit reached");
        end
    end

    initial begin : stimulus
        row_t r;
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_tag_i   = '0;
        req_acc_i   = MEM_ACC_LD;
        req_ls_i    = LS_DOUBLEWORD;
        req_addr_i  = '0;
        req_value_i = '0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        next_tag    = '0;
        build_table();
        repeat (3) @(negedge clk_i);
        arst_n_i = 1'b1;
        assert (!ans_valid_o && req_ready_o) else begin
            $display("** Error at %0t: after reset ans_valid_o=%b req_ready_o=%b",
                     $time, ans_valid_o, req_ready_o);
            abort_run();
        end
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.is_cfg) begin
                drive_cfg(r);
            end else begin
                send_request(r);
            end
        end
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (5) @(negedge clk_i);
        if (n_answers == n_reqs) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("** Error at %0t: %0d answers for %0d requests", $time, n_answers, n_reqs);
            $display("Done: errors found");
            $fatal(1, "Answer count mismatch");
        end
    end

endmodule

/* sim.f */
source/mem_pkg.sv
source/spill_cell.sv
source/mem_cfg_regs.sv
source/mem_access_check.sv
source/mem_array.sv
source/mem_emu_top.sv
test/mem_emu_sva.sv
test/tb_mem_emu.sv

/* Makefile */
TOP := tb_mem_emu

all: run

build:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
